// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Base opcodes, instruction bits 6:0
    localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU ops
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate ALU ops
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // lb lh lw lbu lhu
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // sb sh sw
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // All six conditional branches
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // ALU control codes
    localparam logic [3:0] ALU_ADD    = 4'd0;
    localparam logic [3:0] ALU_SUB    = 4'd1;
    localparam logic [3:0] ALU_SLL    = 4'd2;
    localparam logic [3:0] ALU_SLT    = 4'd3;
    localparam logic [3:0] ALU_SLTU   = 4'd4;
    localparam logic [3:0] ALU_XOR    = 4'd5;
    localparam logic [3:0] ALU_SRL    = 4'd6;
    localparam logic [3:0] ALU_SRA    = 4'd7;
    localparam logic [3:0] ALU_OR     = 4'd8;
    localparam logic [3:0] ALU_AND    = 4'd9;
    localparam logic [3:0] ALU_CMP    = 4'd10; // -1/0/+1, signed
    localparam logic [3:0] ALU_CMPU   = 4'd11; // -1/0/+1, unsigned
    localparam logic [3:0] ALU_PASS_B = 4'd12; // Operand B straight through

    // Operation class, main decoder to ALU decoder
    localparam logic [2:0] ALUOP_ADD     = 3'd0; // Address and link targets
    localparam logic [2:0] ALUOP_BRANCH  = 3'd1; // Compare by funct3
    localparam logic [2:0] ALUOP_FUNCT_R = 3'd2; // funct3/funct7, SUB allowed
    localparam logic [2:0] ALUOP_FUNCT_I = 3'd3; // funct3/funct7, no SUB
    localparam logic [2:0] ALUOP_PASS    = 3'd4; // lui

    // Immediate formats
    localparam logic [2:0] IMM_I = 3'd0;
    localparam logic [2:0] IMM_S = 3'd1;
    localparam logic [2:0] IMM_B = 3'd2;
    localparam logic [2:0] IMM_U = 3'd3;
    localparam logic [2:0] IMM_J = 3'd4;

    // Write-back source
    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2; // Link value for jal/jalr

    // One instruction word, two field views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;   // Sign bit at the top
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } instr_u;

endpackage

`default_nettype wire

// File: main_decoder.sv
`default_nettype none

module main_decoder (
    input  logic [6:0] opcode_i,        // Instruction bits 6:0
    input  logic [2:0] funct3_i,        // Access size for loads and stores
    output logic       reg_wr_en_o,     // rd is written
    output logic       mem_wr_en_o,     // Store
    output logic [2:0] imm_src_o,       // Immediate format
    output logic       alu_src_o,       // 1 = immediate on operand B
    output logic       branch_o,        // Branch or jump
    output logic [1:0] result_src_o,    // Write-back source
    output logic [2:0] alu_op_o,        // Operation class
    output logic [3:0] byte_en_o,       // Unshifted lanes, lane 0 based
    output logic       alu_src_a_sel_o, // 1 = PC on operand A
    output logic       signed_o         // Sign-extend load data
);

    import rv_pkg::*;

    logic [3:0] size_be; // Lanes from access size

    // Byte, half or word
    always_comb begin
        case (funct3_i[1:0])
            2'b00:   size_be = 4'b0001;
            2'b01:   size_be = 4'b0011;
            default: size_be = 4'b1111;
        endcase
    end

    always_comb begin
        reg_wr_en_o     = 1'b0; // Unknown opcodes fall through as no-ops
        mem_wr_en_o     = 1'b0;
        imm_src_o       = IMM_I;
        alu_src_o       = 1'b0;
        branch_o        = 1'b0;
        result_src_o    = RES_ALU;
        alu_op_o        = ALUOP_ADD;
        byte_en_o       = 4'b0000;
        alu_src_a_sel_o = 1'b0;
        signed_o        = 1'b0;
        case (opcode_i)
            OPC_OP: begin
                reg_wr_en_o = 1'b1;
                alu_op_o    = ALUOP_FUNCT_R;
            end
            OPC_OP_IMM: begin
                reg_wr_en_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = ALUOP_FUNCT_I; // No SUB on immediates
            end
            OPC_LOAD: begin
                reg_wr_en_o  = 1'b1;
                alu_src_o    = 1'b1;             // rs1 + offset
                result_src_o = RES_MEM;
                byte_en_o    = size_be;
                signed_o     = ~funct3_i[2];     // lb, lh
            end
            OPC_STORE: begin
                mem_wr_en_o = 1'b1;
                imm_src_o   = IMM_S;
                alu_src_o   = 1'b1;
                byte_en_o   = size_be;
            end
            OPC_BRANCH: begin
                imm_src_o = IMM_B;
                branch_o  = 1'b1;
                alu_op_o  = ALUOP_BRANCH; // Compare rs1 with rs2
            end
            OPC_JAL: begin
                reg_wr_en_o  = 1'b1;
                imm_src_o    = IMM_J;
                branch_o     = 1'b1;
                result_src_o = RES_PC4;
            end
            OPC_JALR: begin
                reg_wr_en_o  = 1'b1;
                alu_src_o    = 1'b1;     // Target is rs1 + imm
                branch_o     = 1'b1;
                result_src_o = RES_PC4;
            end
            OPC_LUI: begin
                reg_wr_en_o = 1'b1;
                imm_src_o   = IMM_U;
                alu_src_o   = 1'b1;
                alu_op_o    = ALUOP_PASS;
            end
            OPC_AUIPC: begin
                reg_wr_en_o     = 1'b1;
                imm_src_o       = IMM_U;
                alu_src_o       = 1'b1;
                alu_src_a_sel_o = 1'b1; // PC + upper immediate
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: alu_decoder.sv
`default_nettype none

module alu_decoder (
    input  logic [2:0] alu_op_i,      // Class from main decoder
    input  logic [2:0] funct3_i,
    input  logic [6:0] funct7_i,      // Only bit 5 matters
    output logic [3:0] alu_control_o
);

    import rv_pkg::*;

    logic alt; // funct7 bit 5, SUB/SRA select

    assign alt = funct7_i[5];

    always_comb begin
        case (alu_op_i)
            ALUOP_BRANCH: begin
                case (funct3_i[2:1])
                    2'b00:   alu_control_o = ALU_SUB;  // beq bne via zero flag
                    2'b10:   alu_control_o = ALU_CMP;  // blt bge
                    default: alu_control_o = ALU_CMPU; // bltu bgeu
                endcase
            end
            ALUOP_FUNCT_R, ALUOP_FUNCT_I: begin
                case (funct3_i)
                    3'b000: begin
                        // SUB only for the register form
                        alu_control_o = (alt && alu_op_i == ALUOP_FUNCT_R) ? ALU_SUB : ALU_ADD;
                    end
                    3'b001:  alu_control_o = ALU_SLL;
                    3'b010:  alu_control_o = ALU_SLT;
                    3'b011:  alu_control_o = ALU_SLTU;
                    3'b100:  alu_control_o = ALU_XOR;
                    3'b101:  alu_control_o = alt ? ALU_SRA : ALU_SRL; // srai keeps bit 30
                    3'b110:  alu_control_o = ALU_OR;
                    default: alu_control_o = ALU_AND;
                endcase
            end
            ALUOP_PASS: alu_control_o = ALU_PASS_B; // lui
            default:    alu_control_o = ALU_ADD;    // Loads, stores, jumps, auipc
        endcase
    end

endmodule

`default_nettype wire

// File: control_unit.sv
`default_nettype none

module control_unit (
    input  logic [6:0]        opcode_i,
    input  logic [2:0]        funct3_i,
    input  logic [6:0]        funct7_i,        // Bit 5 picks SUB/SRA
    input  logic              zero_i,          // ALU result is zero
    input  logic signed [31:0] alu_result_i,   // Sign gives compare outcome
    output logic              reg_wr_en_o,
    output logic              mem_wr_en_o,
    output logic [2:0]        imm_src_o,
    output logic              alu_src_o,
    output logic [1:0]        result_src_o,
    output logic [3:0]        alu_control_o,
    output logic              pc_src_o,        // 1 = redirect PC
    output logic [3:0]        byte_en_o,
    output logic              alu_src_a_sel_o,
    output logic              signed_o
);

    import rv_pkg::*;

    logic [2:0] alu_op;   // Class between the decoders
    logic       branch;   // Branch or jump instruction
    logic       cond_met; // Branch condition from ALU flags

    main_decoder u_main_decoder (
        .opcode_i        (opcode_i),
        .funct3_i        (funct3_i),
        .reg_wr_en_o     (reg_wr_en_o),
        .mem_wr_en_o     (mem_wr_en_o),
        .imm_src_o       (imm_src_o),
        .alu_src_o       (alu_src_o),
        .branch_o        (branch),
        .result_src_o    (result_src_o),
        .alu_op_o        (alu_op),
        .byte_en_o       (byte_en_o),
        .alu_src_a_sel_o (alu_src_a_sel_o),
        .signed_o        (signed_o)
    );

    alu_decoder u_alu_decoder (
        .alu_op_i      (alu_op),
        .funct3_i      (funct3_i),
        .funct7_i      (funct7_i),
        .alu_control_o (alu_control_o)
    );

    always_comb begin
        case (funct3_i)
            3'b000:  cond_met = zero_i;                        // beq
            3'b001:  cond_met = ~zero_i;                       // bne
            3'b100,
            3'b110:  cond_met = (alu_result_i < 0);            // blt bltu, CMP gives -1
            3'b101,
            3'b111:  cond_met = zero_i | (alu_result_i > 0);   // bge bgeu
            default: cond_met = 1'b0;                          // Reserved encodings
        endcase
    end

    // Jumps ignore the condition
    always_comb begin
        case (opcode_i)
            OPC_JAL, OPC_JALR: pc_src_o = branch;
            default:           pc_src_o = branch & cond_met;
        endcase
    end

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  logic [3:0]  alu_control_i,
    output logic [31:0] result_o,
    output logic        zero_o
);

    import rv_pkg::*;

    logic [4:0]  shamt;   // Low five bits of B
    logic [31:0] cmp_s;   // Signed three-way compare
    logic [31:0] cmp_u;   // Unsigned three-way compare

    assign shamt = b_i[4:0];

    // -1 less, 0 equal, +1 greater
    assign cmp_s = ($signed(a_i) < $signed(b_i)) ? 32'hffff_ffff :
                   (a_i == b_i)                  ? 32'd0 : 32'd1;
    assign cmp_u = (a_i < b_i)  ? 32'hffff_ffff :
                   (a_i == b_i) ? 32'd0 : 32'd1;

    always_comb begin
        case (alu_control_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU:   result_o = {31'd0, a_i < b_i};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = $signed(a_i) >>> shamt; // Sign fill
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_CMP:    result_o = cmp_s;
            ALU_CMPU:   result_o = cmp_u;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = 32'd0;
        endcase
    end

    assign zero_o = (result_o == 32'd0); // Equality test for beq/bne

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [4:0]  rd_i,
    input  logic        wr_en_i,
    input  logic [31:0] wr_data_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);

    logic [31:0] regs [1:31]; // x0 has no storage

    // Reset clears all registers and blocks writes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en_i && rd_i != 5'd0) begin // x0 writes dropped
            regs[rd_i] <= wr_data_i;
        end
    end

    // Combinational reads, x0 hardwired
    assign rs1_data_o = (rs1_i == 5'd0) ? 32'd0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? 32'd0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: imm_gen.sv
`default_nettype none

module imm_gen (
    input  rv_pkg::instr_u instr_i,
    input  logic [2:0]     imm_src_i,
    output logic [31:0]    imm_o
);

    import rv_pkg::*;

    logic [31:0] w; // Raw bits, for the scattered formats

    assign w = instr_i;

    always_comb begin
        case (imm_src_i)
            IMM_I:   imm_o = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
            IMM_S:   imm_o = {{20{w[31]}}, instr_i.r_fmt.funct7, instr_i.r_fmt.rd};
            IMM_B:   imm_o = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            IMM_U:   imm_o = {w[31:12], 12'd0};
            IMM_J:   imm_o = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: imm_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: rv_core.sv
`default_nettype none

module rv_core (
    input  logic        clk_i,
    input  logic        rst_n_i,
    output logic [31:0] pc_o,           // Fetch address
    input  logic [31:0] instr_i,        // Same-cycle instruction
    output logic [31:0] dmem_addr_o,
    output logic [31:0] dmem_wdata_o,   // Already in byte lanes
    output logic        dmem_wr_en_o,
    output logic [3:0]  dmem_byte_en_o,
    input  logic [31:0] dmem_rdata_i    // Aligned word
);

    import rv_pkg::*;

    instr_u      instr;
    logic        reg_wr_en;
    logic        mem_wr_en;
    logic [2:0]  imm_src;
    logic        alu_src;
    logic [1:0]  result_src;
    logic [3:0]  alu_control;
    logic        pc_src;
    logic [3:0]  byte_en;      // Lane 0 based
    logic        alu_src_a_sel;
    logic        load_signed;
    logic [31:0] pc_q;
    logic [31:0] pc_plus4;
    logic [31:0] pc_target;    // Branch and jal target
    logic [31:0] pc_next;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        zero;
    logic [4:0]  lane_shift;   // Byte offset in bits
    logic [31:0] load_raw;     // Addressed byte moved to lane 0
    logic [31:0] load_data;
    logic [31:0] wb_data;

    assign instr = instr_i;

    control_unit u_control_unit (
        .opcode_i        (instr.r_fmt.opcode),
        .funct3_i        (instr.r_fmt.funct3),
        .funct7_i        (instr.r_fmt.funct7),
        .zero_i          (zero),
        .alu_result_i    (alu_result),
        .reg_wr_en_o     (reg_wr_en),
        .mem_wr_en_o     (mem_wr_en),
        .imm_src_o       (imm_src),
        .alu_src_o       (alu_src),
        .result_src_o    (result_src),
        .alu_control_o   (alu_control),
        .pc_src_o        (pc_src),
        .byte_en_o       (byte_en),
        .alu_src_a_sel_o (alu_src_a_sel),
        .signed_o        (load_signed)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_i      (instr.r_fmt.rs1),
        .rs2_i      (instr.r_fmt.rs2),
        .rd_i       (instr.r_fmt.rd),
        .wr_en_i    (reg_wr_en),
        .wr_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    imm_gen u_imm_gen (
        .instr_i   (instr),
        .imm_src_i (imm_src),
        .imm_o     (imm)
    );

    assign alu_a = alu_src_a_sel ? pc_q : rs1_data; // auipc uses PC
    assign alu_b = alu_src ? imm : rs2_data;

    alu u_alu (
        .a_i           (alu_a),
        .b_i           (alu_b),
        .alu_control_i (alu_control),
        .result_o      (alu_result),
        .zero_o        (zero)
    );

    assign pc_plus4  = pc_q + 32'd4;
    assign pc_target = pc_q + imm; // B or J immediate per opcode

    // jalr target from ALU with bit 0 cleared
    assign pc_next = !pc_src                               ? pc_plus4 :
                     (instr.r_fmt.opcode == OPC_JALR)       ? {alu_result[31:1], 1'b0} :
                                                              pc_target;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= 32'd0;
        end else begin
            pc_q <= pc_next; // One instruction per edge
        end
    end

    assign pc_o = pc_q;

    // Data memory side
    assign lane_shift     = {alu_result[1:0], 3'b000};
    assign dmem_addr_o    = alu_result;
    assign dmem_wdata_o   = rs2_data << lane_shift;
    assign dmem_byte_en_o = byte_en << alu_result[1:0];
    assign dmem_wr_en_o   = mem_wr_en & rst_n_i; // Held off during reset

    assign load_raw = dmem_rdata_i >> lane_shift;

    // Size from unshifted lanes, extension from funct3
    always_comb begin
        case (byte_en)
            4'b0001: load_data = {{24{load_signed & load_raw[7]}}, load_raw[7:0]};
            4'b0011: load_data = {{16{load_signed & load_raw[15]}}, load_raw[15:0]};
            default: load_data = load_raw;
        endcase
    end

    always_comb begin
        case (result_src)
            RES_MEM: wb_data = load_data;
            RES_PC4: wb_data = pc_plus4; // Link address
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// File: rv_core_asserts.sv
`default_nettype none

module rv_core_asserts (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic [31:0] pc_i,
    input logic        dmem_wr_en_i,
    input logic [3:0]  dmem_byte_en_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0; // Failed property count

    // Reset must hold the store strobe low
    a_no_store_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !dmem_wr_en_i)
        else begin
            $error("store issued while reset is asserted");
            fail_cnt++;
        end

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i) pc_i[1:0] == 2'b00)
        else begin
            $error("pc_o is not word aligned");
            fail_cnt++;
        end

    // One byte, an aligned half or the full word
    a_store_lanes_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dmem_wr_en_i |-> dmem_byte_en_i inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                                4'b0011, 4'b1100, 4'b1111})
        else begin
            $error("store byte enables form an illegal pattern");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`default_nettype none

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int          CLK_PERIOD = 10;
    localparam int          RST_CYCLES = 16;
    localparam int          PROG_LEN   = 400;
    localparam logic [31:0] END_PC     = 32'(4 * (PROG_LEN - 1)); // Self-jump slot

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic [31:0] pc_o;
    logic [31:0] instr_i;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic        dmem_wr_en_o;
    logic [3:0]  dmem_byte_en_o;
    logic [31:0] dmem_rdata_i;

    logic [31:0] imem [0:511];
    logic [31:0] dmem [0:63];   // 256 bytes seen by the DUT
    logic [31:0] m_dmem [0:63]; // Reference model copy
    logic [31:0] m_regs [0:31];
    logic [31:0] m_pc;
    integer      seed;
    int          checks;
    int          errors;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    rv_core u_rv_core (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .pc_o           (pc_o),
        .instr_i        (instr_i),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .dmem_wr_en_o   (dmem_wr_en_o),
        .dmem_byte_en_o (dmem_byte_en_o),
        .dmem_rdata_i   (dmem_rdata_i)
    );

    bind rv_core rv_core_asserts u_rv_core_asserts (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .pc_i           (pc_o),
        .dmem_wr_en_i   (dmem_wr_en_o),
        .dmem_byte_en_i (dmem_byte_en_o)
    );

    // Combinational memories
    assign instr_i      = imem[pc_o[10:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    always @(posedge clk_i) begin
        if (dmem_wr_en_o) begin
            dmem[dmem_addr_o[7:2]] <= merge_lanes(dmem[dmem_addr_o[7:2]], dmem_wdata_o,
                                                  dmem_byte_en_o);
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // RV32I integer op semantics by funct3 and the bit-30 variant
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0]; // Sign fill
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp_v,
                                input logic [31:0] got_v);
        checks++;
        assert (got_v === exp_v) else begin
            $display("FAIL %s expected %h got %h", name, exp_v, got_v);
            errors++;
        end
    endtask

    task automatic print_test_line(input string name, input int c0, input int e0);
        $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    task automatic init_state();
        for (int i = 0; i < 512; i++) begin
            imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, OPC_OP_IMM}; // No-op addi to x0
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]   = (32'(i) * 32'h0104_0811) ^ 32'hc3a5_5a3c; // Distinct per word
            m_dmem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'd0;
        end
        m_pc = 32'd0;
    endtask

    // Forward-only control flow with aligned x0-based data accesses
    task automatic gen_program();
        int          i;
        int          k;
        int unsigned kind;
        int unsigned sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [20:0] off;
        imem[0] = {7'd0, 5'd0, 5'd0, 3'b010, 5'd0, OPC_STORE}; // sw at the reset PC
        i = 1;
        while (i < PROG_LEN - 1) begin
            kind = rand_below(8);
            rd   = 5'(rand_below(32)); // x0 included on purpose
            rs1  = 5'(rand_below(32));
            rs2  = (rand_below(4) == 0) ? rs1 : 5'(rand_below(32)); // Some equal operands
            f3   = 3'(rand_below(8));
            k    = 1 + rand_below(8);
            if (i + k > PROG_LEN - 1) k = PROG_LEN - 1 - i; // Stay inside the program
            case (kind)
                0: begin
                    f7 = ((f3 == 3'b000 || f3 == 3'b101) && rand_below(2) == 1) ? 7'h20 : 7'h00;
                    imem[i] = {f7, rs2, rs1, f3, rd, OPC_OP};
                end
                1: begin
                    imm = 12'(rand_below(4096));
                    if (f3 == 3'b001) imm[11:5] = 7'h00;
                    if (f3 == 3'b101) imm[11:5] = (rand_below(2) == 1) ? 7'h20 : 7'h00;
                    imem[i] = {imm, rs1, f3, rd, OPC_OP_IMM};
                end
                2: imem[i] = {20'(rand_below(1 << 20)), rd,
                              (rand_below(2) == 1) ? OPC_LUI : OPC_AUIPC};
                3: begin
                    sel = rand_below(5);
                    f3  = (sel < 3) ? 3'(sel) : 3'(sel + 1); // lb lh lw lbu lhu
                    imm = 12'(rand_below(256) & ~((1 << f3[1:0]) - 1));
                    imem[i] = {imm, 5'd0, f3, rd, OPC_LOAD};
                end
                4: begin
                    f3  = 3'(rand_below(3)); // sb sh sw
                    imm = 12'(rand_below(256) & ~((1 << f3[1:0]) - 1));
                    imem[i] = {imm[11:5], rs2, 5'd0, f3, imm[4:0], OPC_STORE};
                end
                5: begin
                    sel = rand_below(6);
                    f3  = (sel < 2) ? 3'(sel) : 3'(sel + 2); // Skip reserved 010 011
                    off = 21'(4 * k);
                    imem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
                end
                6: begin
                    off = 21'(4 * k);
                    imem[i] = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
                end
                default: begin
                    imm = 12'(4 * (i + k)); // Absolute target through x0
                    imem[i] = {imm, 5'd0, 3'b000, rd, OPC_JALR};
                end
            endcase
            // Expose rd through a store
            if (kind != 4 && kind != 5 && i < PROG_LEN - 2) begin
                i++;
                imm = 12'(4 * rand_below(64));
                imem[i] = {imm[11:5], rd, 5'd0, 3'b010, imm[4:0], OPC_STORE};
            end
            i++;
        end
        imem[PROG_LEN - 1] = {25'd0, OPC_JAL}; // jal x0, 0
    endtask

    // One ISA step from m_pc after checking the DUT's current cycle
    task automatic step_and_check();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] rd_val;
        logic [31:0] nxt;
        logic [31:0] mask;
        logic [3:0]  exp_be;
        logic [4:0]  sh;
        logic        wr_rd;
        logic        taken;
        w      = imem[m_pc[10:2]];
        a      = m_regs[w[19:15]];
        b      = m_regs[w[24:20]];
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
        nxt    = m_pc + 32'd4;
        rd_val = 32'd0;
        wr_rd  = 1'b1;
        taken  = 1'b0;
        addr   = (w[6:0] == OPC_STORE) ? a + imm_s : a + imm_i;
        sh     = {addr[1:0], 3'b000};
        exp_be = ((w[13:12] == 2'b00) ? 4'b0001 : (w[13:12] == 2'b01) ? 4'b0011 : 4'b1111)
                 << addr[1:0];
        compare_word("pc_o", m_pc, pc_o);
        case (w[6:0])
            OPC_OP:     rd_val = alu_ref(w[14:12], w[30], a, b);
            OPC_OP_IMM: rd_val = alu_ref(w[14:12], w[14:12] == 3'b101 && w[30], a, imm_i);
            OPC_LUI:    rd_val = {w[31:12], 12'd0};
            OPC_AUIPC:  rd_val = m_pc + {w[31:12], 12'd0};
            OPC_LOAD: begin
                word = m_dmem[addr[7:2]] >> sh;
                case (w[13:12])
                    2'b00:   rd_val = {{24{word[7] & ~w[14]}}, word[7:0]};
                    2'b01:   rd_val = {{16{word[15] & ~w[14]}}, word[15:0]};
                    default: rd_val = word;
                endcase
                compare_word("dmem_addr_o", addr, dmem_addr_o);
                compare_word("dmem_byte_en_o", {28'd0, exp_be}, {28'd0, dmem_byte_en_o});
            end
            OPC_STORE: begin
                wr_rd = 1'b0;
                mask  = {{8{exp_be[3]}}, {8{exp_be[2]}}, {8{exp_be[1]}}, {8{exp_be[0]}}};
                compare_word("dmem_addr_o", addr, dmem_addr_o);
                compare_word("dmem_byte_en_o", {28'd0, exp_be}, {28'd0, dmem_byte_en_o});
                compare_word("dmem_wdata_o", (b << sh) & mask, dmem_wdata_o & mask);
                m_dmem[addr[7:2]] = merge_lanes(m_dmem[addr[7:2]], b << sh, exp_be);
            end
            OPC_BRANCH: begin
                wr_rd = 1'b0;
                case (w[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) nxt = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            OPC_JAL: begin
                rd_val = m_pc + 32'd4;
                nxt    = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            OPC_JALR: begin
                rd_val = m_pc + 32'd4;
                nxt    = (a + imm_i) & ~32'd1;
            end
            default: wr_rd = 1'b0; // Unsupported opcode is a no-op
        endcase
        compare_word("dmem_wr_en_o", {31'd0, w[6:0] == OPC_STORE}, {31'd0, dmem_wr_en_o});
        if (wr_rd && w[11:7] != 5'd0) m_regs[w[11:7]] = rd_val; // x0 stays zero
        m_pc = nxt;
    endtask

    initial begin
        #((RST_CYCLES + 20 * PROG_LEN) * CLK_PERIOD); // 20 cycles per instruction
        $display("watchdog timeout: program never reached its final self-jump");
        $display("tests failed");
        $finish;
    end

    initial begin
        int c0;
        int e0;
        seed    = 32'hea2b;
        checks  = 0;
        errors  = 0;
        rst_n_i = 1'b0;
        init_state();
        gen_program();
        c0 = checks;
        e0 = errors;
        repeat (RST_CYCLES) begin
            @(negedge clk_i);
            compare_word("pc_o", 32'd0, pc_o);
            compare_word("dmem_wr_en_o", 32'd0, {31'd0, dmem_wr_en_o});
        end
        @(posedge clk_i);
        rst_n_i <= 1'b1;
        print_test_line("reset", c0, e0);
        c0 = checks;
        e0 = errors;
        while (m_pc != END_PC) begin
            @(negedge clk_i);
            step_and_check();
        end
        print_test_line("random program", c0, e0);
        c0 = checks;
        e0 = errors;
        repeat (4) begin
            @(negedge clk_i);
            step_and_check(); // PC must hold on the self-jump
        end
        print_test_line("self-jump hold", c0, e0);
        errors += u_rv_core.u_rv_core_asserts.fail_cnt; // Failures of the bound checker
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rv_pkg.sv
main_decoder.sv
alu_decoder.sv
control_unit.sv
alu.sv
reg_file.sv
imm_gen.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv
